// ==== build.f ====
soc_pkg.sv
sync_fifo.sv
uart_tx.sv
spi_master.sv
soc_bus.sv
soc_toplevel.sv
tb_sopc_sva.sv
tb_sopc.sv

// ==== run_sim.sh ====
#!/bin/bash
# Build and run the SoC testbench with Verilator
cd "$(dirname "$0")" || exit 1
rm -f sim.log
verilator --binary --timing --assert --timescale 1ns/1ps --top-module tb_sopc \
   -f build.f -o Vtb_sopc \
   && ./obj_dir/Vtb_sopc > sim.log 2>&1 \
   || { cat sim.log 2>/dev/null; echo "Build or simulation did not complete"; exit 1; }
cat sim.log
grep -q "Done: errors found" sim.log && { echo "FAIL"; exit 1; } || { echo "PASS"; exit 0; }

// ==== tb_sopc.sv ====
`timescale 1ns/1ps
`default_nettype none

module tb_sopc;

   import soc_pkg::*;

   logic        clk;
   logic        rst_n;
   bus_req_t    bus_req;
   bus_rsp_t    bus_rsp;
   logic        uart_tx_l;
   logic        spi_sck;
   logic        spi_cs_l;
   logic        spi_mosi;
   logic        spi_miso;
   logic [31:0] lfsr;
   int          checks;
   int          errors;
   int          timeouts;

   assign spi_miso = spi_mosi;   // Loopback like the flash pins

   soc_toplevel DUT (
      .clk       (clk),
      .rst_n     (rst_n),
      .bus_req   (bus_req),
      .bus_rsp   (bus_rsp),
      .uart_tx_l (uart_tx_l),
      .spi_sck   (spi_sck),
      .spi_cs_l  (spi_cs_l),
      .spi_mosi  (spi_mosi),
      .spi_miso  (spi_miso)
   );

   always #5 clk = ~clk;

   // Fibonacci LFSR, taps 32 22 2 1, one step per bit
   function automatic logic [31:0] rand_bits(input int n);
      logic [31:0] w;
      logic        fb;
      w = '0;
      for (int i = 0; i < n; i++) begin
         fb   = lfsr[31] ^ lfsr[21] ^ lfsr[1] ^ lfsr[0];
         lfsr = {lfsr[30:0], fb};
         w    = {w[30:0], fb};
      end
      return w;
   endfunction

   // Distinct word slots spread over the RAM
   function automatic logic [11:0] ram_addr(input int i);
      return ADDR_RAM_BASE + 12'(((i * 5 + 3) % RAM_WORDS) * 4);
   endfunction

   task automatic end_run();
      $display("Checks: %0d, errors: %0d, timeouts: %0d", checks, errors, timeouts);
      if (errors == 0 && timeouts == 0)
         $display("Done: no errors");
      else
         $display("Done: errors found");
      $finish;
   endtask

   task automatic timeout_abort(input string what);
      timeouts++;
      $display("Timed out waiting for %s", what);
      end_run();
   endtask

   task automatic check_value(input string what, input logic [31:0] got,
                              input logic [31:0] exp);
      checks++;
      assert (got === exp) else begin
         errors++;
         $display("error at %0t: %s is %h, expected %h", $time, what, got, exp);
      end
   endtask

   // Bus tasks start and end 1 ns after a rising edge
   task automatic bus_write(input logic [11:0] a, input logic [31:0] d);
      bus_req = '{valid: 1'b1, we: 1'b1, addr: a, wdata: d};
      @(posedge clk);
      #1;
      bus_req = '0;
   endtask

   task automatic bus_read(input logic [11:0] a, output logic [31:0] d);
      bus_req = '{valid: 1'b1, we: 1'b0, addr: a, wdata: 32'd0};
      @(posedge clk);
      #1;
      bus_req = '0;
      check_value($sformatf("rvalid for read of %h", a), 32'(bus_rsp.rvalid), 32'd1);
      d = bus_rsp.rdata;
   endtask

   task automatic wait_start_bit(input int limit, output bit found);
      logic prev;
      found = 1'b0;
      prev  = uart_tx_l;
      for (int n = 0; n < limit && !found; n++) begin
         @(posedge clk);
         #1;
         found = prev && !uart_tx_l;
         prev  = uart_tx_l;
      end
   endtask

   // Serial decoder, samples in the middle of each bit
   task automatic uart_receive(output logic [7:0] b);
      bit found;
      wait_start_bit(2 * 10 * UART_DIV, found);
      if (!found)
         timeout_abort("a UART start bit");
      repeat (UART_DIV / 2) @(posedge clk);
      #1;
      check_value("UART start bit", 32'(uart_tx_l), 32'd0);
      for (int i = 0; i < 8; i++) begin
         repeat (UART_DIV) @(posedge clk);
         #1;
         b[i] = uart_tx_l;   // LSB first
      end
      repeat (UART_DIV) @(posedge clk);
      #1;
      check_value("UART stop bit", 32'(uart_tx_l), 32'd1);
   endtask

   // Counts SCK rises until chip select reaches the given level
   task automatic watch_cs(input logic level, input int limit, inout int rises);
      logic prev;
      bit   done;
      prev = spi_sck;
      done = 1'b0;
      for (int n = 0; n < limit && !done; n++) begin
         @(posedge clk);
         #1;
         if (spi_sck && !prev)
            rises++;
         prev = spi_sck;
         done = (spi_cs_l == level);
      end
      if (!done)
         timeout_abort($sformatf("SPI chip select to reach %0b", level));
   endtask

   task automatic test_reset();
      logic [31:0] rd;
      check_value("uart_tx_l after reset", 32'(uart_tx_l), 32'd1);
      check_value("spi_cs_l after reset", 32'(spi_cs_l), 32'd1);
      check_value("spi_sck after reset", 32'(spi_sck), 32'd0);
      check_value("spi_mosi after reset", 32'(spi_mosi), 32'd0);
      check_value("rvalid after reset", 32'(bus_rsp.rvalid), 32'd0);
      bus_read(ADDR_STATUS, rd);
      check_value("status after reset", rd, 32'd0);
   endtask

   task automatic test_ram();
      logic [31:0] words [16];
      logic [11:0] unmapped [4];
      logic [31:0] rd;
      unmapped = '{12'h010, 12'h0FC, 12'h200, 12'hFFC};
      for (int i = 0; i < 16; i++) begin
         words[i] = rand_bits(32);
         bus_write(ram_addr(i), words[i]);
      end
      for (int i = 0; i < 16; i++) begin
         bus_read(ram_addr(i), rd);
         check_value($sformatf("RAM at %h", ram_addr(i)), rd, words[i]);
      end
      for (int i = 0; i < 4; i++) begin
         bus_read(unmapped[i], rd);
         check_value($sformatf("unmapped %h", unmapped[i]), rd, 32'd0);
      end
   endtask

   task automatic test_uart();
      logic [7:0]  sent [3];
      logic [7:0]  got;
      logic [31:0] rd;
      for (int i = 0; i < 3; i++)
         sent[i] = 8'(rand_bits(8));
      fork
         for (int i = 0; i < 3; i++)
            bus_write(ADDR_UART_DATA, {24'b0, sent[i]});
         for (int j = 0; j < 3; j++) begin
            uart_receive(got);
            check_value("UART byte", 32'(got), 32'(sent[j]));
         end
      join
      repeat (UART_DIV) @(posedge clk);   // Past the end of the stop bit
      #1;
      bus_read(ADDR_STATUS, rd);
      check_value("status after UART", rd, 32'd0);
   endtask

   task automatic test_spi();
      logic [7:0]  sent [3];
      logic [31:0] rd;
      int          rises;
      int          extra;
      for (int i = 0; i < 3; i++)
         sent[i] = 8'(rand_bits(8));
      rises = 0;
      extra = 0;
      fork
         begin
            bus_write(ADDR_SPI_DATA, {24'b0, sent[0]});
            bus_write(ADDR_SPI_DATA, {24'b0, sent[1]});
            bus_write(ADDR_SPI_DATA, {23'b0, 1'b1, sent[2]});   // Bit 8 is last
         end
         begin
            watch_cs(1'b0, 16, rises);
            watch_cs(1'b1, 3 * 16 * SPI_DIV + 16, rises);
         end
      join
      for (int n = 0; n < 8 * SPI_DIV; n++) begin
         @(posedge clk);
         #1;
         if (!spi_cs_l || spi_sck)
            extra++;
      end
      check_value("SPI activity after release", 32'(extra), 32'd0);
      check_value("SCK rises", 32'(rises), 32'd24);
      bus_read(ADDR_SPI_RX, rd);
      check_value("SPI received byte", rd, {24'b0, sent[2]});
   endtask

   task automatic test_overflow();
      logic [7:0]  sent [6];
      logic [7:0]  got;
      logic [31:0] rd;
      bit          found;
      for (int i = 0; i < 6; i++)
         sent[i] = 8'(rand_bits(8));
      fork
         begin
            for (int i = 0; i < 6; i++)
               bus_write(ADDR_UART_DATA, {24'b0, sent[i]});
            bus_read(ADDR_STATUS, rd);
            check_value("status after overflow", rd, 32'h13);   // Overflow, busy, full
            bus_read(ADDR_STATUS, rd);
            check_value("status after clearing read", rd, 32'h03);
         end
         for (int j = 0; j < 5; j++) begin
            uart_receive(got);
            check_value("UART byte after overflow", 32'(got), 32'(sent[j]));
         end
      join
      wait_start_bit(2 * 10 * UART_DIV, found);
      check_value("start bit of the dropped byte", 32'(found), 32'd0);
   endtask

   initial begin
      clk      = 1'b0;
      rst_n    = 1'b0;
      bus_req  = '0;
      lfsr     = 32'h50cd;
      checks   = 0;
      errors   = 0;
      timeouts = 0;
      repeat (16) @(posedge clk);
      #1;
      rst_n = 1'b1;
      test_reset();
      test_ram();
      test_uart();
      test_spi();
      test_overflow();
      end_run();
   end

endmodule

`default_nettype wire

// ==== tb_sopc_sva.sv ====
`timescale 1ns/1ps
`default_nettype none

module tb_sopc_sva (
   input wire                    clk,
   input wire                    rst_n,
   input wire soc_pkg::bus_req_t bus_req,
   input wire soc_pkg::bus_rsp_t bus_rsp,
   input wire                    uart_tx_l,
   input wire                    spi_sck,
   input wire                    spi_cs_l
);

   import soc_pkg::*;

   logic rd_req;

   assign rd_req = bus_req.valid && !bus_req.we;

   // Two rvalid cycles in a row need a read in each cycle before
   a_rvalid_pairs: assert property (@(posedge clk) disable iff (!rst_n)
      bus_rsp.rvalid && $past(bus_rsp.rvalid) |-> $past(rd_req) && $past(rd_req, 2))
      else $error("rvalid held for two cycles without a read in each");

   // SCK low while CS is high and for the setup half period after it falls
   a_sck_idle: assert property (@(posedge clk) disable iff (!rst_n)
      spi_cs_l || $past(spi_cs_l, SPI_DIV) |-> !spi_sck)
      else $error("SCK high while chip select is released or within its setup time");

   a_reset_idle: assert property (@(posedge clk) !rst_n |-> uart_tx_l && spi_cs_l)
      else $error("UART line or chip select low during reset");

endmodule

bind soc_toplevel tb_sopc_sva sva0 (
   .clk       (clk),
   .rst_n     (rst_n),
   .bus_req   (bus_req),
   .bus_rsp   (bus_rsp),
   .uart_tx_l (uart_tx_l),
   .spi_sck   (spi_sck),
   .spi_cs_l  (spi_cs_l)
);

`default_nettype wire

// ==== soc_toplevel.sv ====
`timescale 1ns/1ps
`default_nettype none

module soc_toplevel (
   input  wire                    clk,
   input  wire                    rst_n,
   input  wire soc_pkg::bus_req_t bus_req,
   output wire soc_pkg::bus_rsp_t bus_rsp,
   output wire                    uart_tx_l,
   output wire                    spi_sck,
   output wire                    spi_cs_l,
   output wire                    spi_mosi,
   input  wire                    spi_miso
);

   import soc_pkg::*;

   logic       uart_push;
   logic       uart_pop;
   logic       uart_full;
   logic       uart_empty;
   logic       uart_busy;
   logic [7:0] uart_head;

   logic       spi_push;
   logic       spi_pop;
   logic       spi_full;
   logic       spi_empty;
   logic       spi_busy;
   logic [7:0] spi_rx;
   spi_frame_t spi_push_frame;
   spi_frame_t spi_head;

   // Register decode, status, RAM
   soc_bus bus0 (
      .clk       (clk),
      .rst_n     (rst_n),
      .bus_req   (bus_req),
      .bus_rsp   (bus_rsp),
      .uart_push (uart_push),
      .uart_full (uart_full),
      .uart_busy (uart_busy),
      .spi_push  (spi_push),
      .spi_frame (spi_push_frame),
      .spi_full  (spi_full),
      .spi_busy  (spi_busy),
      .spi_rx    (spi_rx)
   );

   sync_fifo #(
      .T     (logic [7:0]),
      .DEPTH (FIFO_DEPTH)
   ) uart_fifo (
      .clk       (clk),
      .rst_n     (rst_n),
      .push      (uart_push),
      .push_data (bus_req.wdata[7:0]),   // Low byte of the write
      .pop       (uart_pop),
      .pop_data  (uart_head),
      .full      (uart_full),
      .empty     (uart_empty)
   );

   sync_fifo #(
      .T     (spi_frame_t),
      .DEPTH (FIFO_DEPTH)
   ) spi_fifo (
      .clk       (clk),
      .rst_n     (rst_n),
      .push      (spi_push),
      .push_data (spi_push_frame),
      .pop       (spi_pop),
      .pop_data  (spi_head),
      .full      (spi_full),
      .empty     (spi_empty)
   );

   uart_tx uart0 (
      .clk        (clk),
      .rst_n      (rst_n),
      .fifo_empty (uart_empty),
      .fifo_data  (uart_head),
      .fifo_pop   (uart_pop),
      .busy       (uart_busy),
      .tx_l       (uart_tx_l)
   );

   spi_master spi0 (
      .clk        (clk),
      .rst_n      (rst_n),
      .fifo_empty (spi_empty),
      .fifo_frame (spi_head),
      .fifo_pop   (spi_pop),
      .busy       (spi_busy),
      .rx_byte    (spi_rx),
      .sck        (spi_sck),
      .cs_l       (spi_cs_l),
      .mosi       (spi_mosi),
      .miso       (spi_miso)
   );

endmodule

`default_nettype wire

// ==== soc_bus.sv ====
`timescale 1ns/1ps
`default_nettype none

module soc_bus (
   input  wire                  clk,
   input  wire                  rst_n,
   input  wire soc_pkg::bus_req_t bus_req,
   output soc_pkg::bus_rsp_t    bus_rsp,
   output logic                 uart_push,
   input  wire                  uart_full,
   input  wire                  uart_busy,
   output logic                 spi_push,
   output soc_pkg::spi_frame_t  spi_frame,
   input  wire                  spi_full,
   input  wire                  spi_busy,
   input  wire [7:0]            spi_rx
);

   import soc_pkg::*;

   localparam int RAM_AW = $clog2(RAM_WORDS);

   logic [31:0]       ram [RAM_WORDS];
   logic [RAM_AW-1:0] ram_idx;
   logic              sel_ram;
   logic              wr;
   logic              rd;
   logic              status_rd;
   logic              ovf;
   logic              ovf_set;
   logic [31:0]       rd_mux;

   assign wr        = bus_req.valid && bus_req.we;
   assign rd        = bus_req.valid && !bus_req.we;
   assign sel_ram   = (bus_req.addr[11:8] == ADDR_RAM_BASE[11:8]);
   assign ram_idx   = bus_req.addr[RAM_AW+1:2];   // Word address
   assign status_rd = rd && (bus_req.addr == ADDR_STATUS);

   assign uart_push = wr && (bus_req.addr == ADDR_UART_DATA);
   assign spi_push  = wr && (bus_req.addr == ADDR_SPI_DATA);
   assign spi_frame = '{data: bus_req.wdata[7:0], last: bus_req.wdata[8]};

   assign ovf_set = (uart_push && uart_full) || (spi_push && spi_full);

   // A new overflow wins over the clearing read
   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n)
         ovf <= 1'b0;
      else
         ovf <= (ovf && !status_rd) || ovf_set;
   end

   always_ff @(posedge clk) begin
      if (wr && sel_ram)
         ram[ram_idx] <= bus_req.wdata;
   end

   always_comb begin
      rd_mux = '0;   // Unmapped reads give zero
      if (sel_ram) begin
         rd_mux = ram[ram_idx];
      end else begin
         case (bus_req.addr)
            ADDR_STATUS: rd_mux = {27'b0, ovf, spi_busy, spi_full, uart_busy, uart_full};
            ADDR_SPI_RX: rd_mux = {24'b0, spi_rx};
            default:     ;
         endcase
      end
   end

   // Fixed one cycle read latency
   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         bus_rsp <= '0;
      end else begin
         bus_rsp.rvalid <= rd;
         if (rd)
            bus_rsp.rdata <= rd_mux;
      end
   end

endmodule

`default_nettype wire

// ==== spi_master.sv ====
`timescale 1ns/1ps
`default_nettype none

module spi_master (
   input  wire                  clk,
   input  wire                  rst_n,
   input  wire                  fifo_empty,
   input  wire soc_pkg::spi_frame_t fifo_frame,
   output logic                 fifo_pop,
   output logic                 busy,
   output logic [7:0]           rx_byte,
   output logic                 sck,
   output logic                 cs_l,
   output logic                 mosi,
   input  wire                  miso
);

   import soc_pkg::*;

   localparam int DW = $clog2(SPI_DIV);
   localparam logic [DW-1:0] DIV_LAST = DW'(SPI_DIV - 1);

   // The first low half of SCK in a sequence is the CS setup time
   typedef enum logic [1:0] {
      ST_IDLE,
      ST_SHIFT,
      ST_HOLD,      // CS low, waiting for the next frame
      ST_RELEASE    // CS high for one half period
   } state_t;

   state_t        state;
   logic [DW-1:0] div_cnt;
   logic [3:0]    phase_cnt;   // Even is SCK low, odd is SCK high
   logic [7:0]    tx_sh;
   logic [7:0]    rx_sh;
   logic          last_q;
   logic          half_end;
   logic          byte_end;
   logic          load;

   assign half_end = (div_cnt == DIV_LAST);
   assign byte_end = (state == ST_SHIFT) && half_end && (phase_cnt == 4'd15);

   assign load = !fifo_empty &&
                 ((state == ST_IDLE) || (state == ST_HOLD) || (byte_end && !last_q));

   assign fifo_pop = load;
   assign busy     = (state != ST_IDLE);
   assign cs_l     = (state == ST_IDLE) || (state == ST_RELEASE);
   assign sck      = (state == ST_SHIFT) && phase_cnt[0];
   assign mosi     = (state == ST_SHIFT) && tx_sh[7];   // MSB first

   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         state     <= ST_IDLE;
         div_cnt   <= '0;
         phase_cnt <= '0;
         last_q    <= 1'b0;
      end else if (load) begin
         state     <= ST_SHIFT;
         div_cnt   <= '0;
         phase_cnt <= '0;
         last_q    <= fifo_frame.last;
      end else begin
         case (state)
            ST_SHIFT: begin
               if (half_end) begin
                  div_cnt   <= '0;
                  phase_cnt <= phase_cnt + 1'b1;
                  if (byte_end)
                     state <= last_q ? ST_RELEASE : ST_HOLD;
               end else begin
                  div_cnt <= div_cnt + 1'b1;
               end
            end
            ST_RELEASE: begin
               if (half_end) begin
                  div_cnt <= '0;
                  state   <= ST_IDLE;
               end else begin
                  div_cnt <= div_cnt + 1'b1;
               end
            end
            default: ;
         endcase
      end
   end

   always_ff @(posedge clk) begin
      if (load)
         tx_sh <= fifo_frame.data;
      else if ((state == ST_SHIFT) && half_end && phase_cnt[0])
         tx_sh <= {tx_sh[6:0], 1'b0};        // Falling SCK
      if ((state == ST_SHIFT) && half_end && !phase_cnt[0])
         rx_sh <= {rx_sh[6:0], miso};        // Rising SCK
   end

   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n)
         rx_byte <= '0;
      else if (byte_end)
         rx_byte <= rx_sh;
   end

endmodule

`default_nettype wire

// ==== uart_tx.sv ====
`timescale 1ns/1ps
`default_nettype none

module uart_tx (
   input  wire       clk,
   input  wire       rst_n,
   input  wire       fifo_empty,
   input  wire [7:0] fifo_data,
   output logic      fifo_pop,
   output logic      busy,
   output logic      tx_l
);

   import soc_pkg::*;

   localparam int BW = $clog2(UART_DIV);
   localparam logic [BW-1:0] BAUD_LAST = BW'(UART_DIV - 1);

   logic [BW-1:0] baud_cnt;
   logic [3:0]    bit_cnt;    // 0 is the start bit, 9 the stop bit
   logic [9:0]    shreg;
   logic          bit_end;
   logic          frame_end;

   assign bit_end   = (baud_cnt == BAUD_LAST);
   assign frame_end = busy && bit_end && (bit_cnt == 4'd9);

   // Reload straight after the stop bit so bytes run back to back
   assign fifo_pop = (!busy || frame_end) && !fifo_empty;

   assign tx_l = busy ? shreg[0] : 1'b1;   // Line idles high

   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         busy     <= 1'b0;
         baud_cnt <= '0;
         bit_cnt  <= '0;
      end else if (fifo_pop) begin
         busy     <= 1'b1;
         baud_cnt <= '0;
         bit_cnt  <= '0;
      end else if (frame_end) begin
         busy <= 1'b0;
      end else if (busy) begin
         if (bit_end) begin
            baud_cnt <= '0;
            bit_cnt  <= bit_cnt + 1'b1;
         end else begin
            baud_cnt <= baud_cnt + 1'b1;
         end
      end
   end

   // Stop, data LSB first, start
   always_ff @(posedge clk) begin
      if (fifo_pop)
         shreg <= {1'b1, fifo_data, 1'b0};
      else if (busy && bit_end)
         shreg <= {1'b1, shreg[9:1]};
   end

endmodule

`default_nettype wire

// ==== sync_fifo.sv ====
`timescale 1ns/1ps
`default_nettype none

module sync_fifo #(
   parameter type T     = logic [7:0],
   parameter int  DEPTH = 4
) (
   input  wire   clk,
   input  wire   rst_n,
   input  wire   push,
   input  wire T push_data,
   input  wire   pop,
   output T      pop_data,
   output logic  full,
   output logic  empty
);

   localparam int AW = $clog2(DEPTH);
   localparam logic [AW-1:0] PTR_LAST = AW'(DEPTH - 1);
   localparam logic [AW:0]   CNT_FULL = (AW + 1)'(DEPTH);

   T              mem [DEPTH];
   logic [AW-1:0] wr_ptr;
   logic [AW-1:0] rd_ptr;
   logic [AW:0]   count;
   logic          do_push;
   logic          do_pop;

   assign full     = (count == CNT_FULL);
   assign empty    = (count == '0);
   assign do_push  = push && !full;   // Dropped when full, even with a pop
   assign do_pop   = pop && !empty;
   assign pop_data = mem[rd_ptr];     // Head entry

   always_ff @(posedge clk) begin
      if (do_push)
         mem[wr_ptr] <= push_data;
   end

   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         wr_ptr <= '0;
         rd_ptr <= '0;
         count  <= '0;
      end else begin
         if (do_push)
            wr_ptr <= (wr_ptr == PTR_LAST) ? '0 : wr_ptr + 1'b1;
         if (do_pop)
            rd_ptr <= (rd_ptr == PTR_LAST) ? '0 : rd_ptr + 1'b1;
         case ({do_push, do_pop})
            2'b10:   count <= count + 1'b1;
            2'b01:   count <= count - 1'b1;
            default: ;   // Both or neither
         endcase
      end
   end

endmodule

`default_nettype wire

// ==== soc_pkg.sv ====
`default_nettype none

package soc_pkg;

   // One CPU access, valid for a single cycle
   typedef struct packed {
      logic        valid;
      logic        we;
      logic [11:0] addr;
      logic [31:0] wdata;
   } bus_req_t;

   // Read response, one cycle after the request
   typedef struct packed {
      logic        rvalid;
      logic [31:0] rdata;
   } bus_rsp_t;

   // SPI byte plus end of chip select sequence
   typedef struct packed {
      logic [7:0] data;
      logic       last;   // Release CS after this byte
   } spi_frame_t;

   // Register map
   localparam logic [11:0] ADDR_UART_DATA = 12'h000;
   localparam logic [11:0] ADDR_STATUS    = 12'h004;
   localparam logic [11:0] ADDR_SPI_DATA  = 12'h008;
   localparam logic [11:0] ADDR_SPI_RX    = 12'h00C;
   localparam logic [11:0] ADDR_RAM_BASE  = 12'h100;   // Up to 0x1FC

   localparam int RAM_WORDS  = 64;
   localparam int FIFO_DEPTH = 4;

   // Clocks per UART bit
   localparam int UART_DIV = 16;
   // Clocks per half SCK period
   localparam int SPI_DIV  = 4;

endpackage

`default_nettype wire
